// ==== common/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// physical address width in bits.
`define MEM_ADDR_W 32

// one cache line, eight 32-bit words.
`define MEM_LINE_W 256

// lines held by the memory model.
`define MEM_LINES 16

// byte offset inside a line.
`define MEM_OFFSET_BITS 5

// cycles from request start at the memory to resp, resp included.
`define MEM_LATENCY 4

`endif

// ==== common/mem_types_pkg.sv ====
`include "mem_consts.svh"

package mem_types_pkg;

    // byte address, one word.
    typedef logic [`MEM_ADDR_W-1:0] addr_t;

    // whole cache line.
    typedef logic [`MEM_LINE_W-1:0] line_t;

    // line slot in the array.
    typedef logic [$clog2(`MEM_LINES)-1:0] line_idx_t;

    // index sits just above the byte offset.
    function automatic line_idx_t line_index(input addr_t address);
        return address[`MEM_OFFSET_BITS +: $bits(line_idx_t)];
    endfunction

endpackage

// ==== common/arb_pkg.sv ====
package arb_pkg;

    typedef enum logic [1:0] {
        arb_idle,
        arb_serve_i,
        arb_serve_d
    } arb_state_t;

    // operation presented at the memory.
    typedef enum logic [1:0] {
        op_none,
        op_read,
        op_write
    } mem_op_t;

endpackage

// ==== common/line_bus_if.sv ====
`timescale 1ns/1ps

interface line_bus_if;

    mem_types_pkg::addr_t address;
    mem_types_pkg::line_t wdata;
    logic                 read;
    logic                 write;
    mem_types_pkg::line_t rdata;
    logic                 resp;

    modport requester (
        output address,
        output wdata,
        output read,
        output write,
        input  rdata,
        input  resp
    );

    modport memory (
        input  address,
        input  wdata,
        input  read,
        input  write,
        output rdata,
        output resp
    );

    // line store only, the timer owns resp.
    modport store (
        input  address,
        input  wdata,
        input  write,
        input  resp,
        output rdata
    );

endinterface

// ==== arbiter/arbiter.sv ====
`timescale 1ns/1ps

module arbiter (
    input  logic                 clk,
    input  logic                 rst,

    input  mem_types_pkg::addr_t i_address,
    input  logic                 i_read,
    output mem_types_pkg::line_t i_rdata,
    output logic                 i_resp,

    input  mem_types_pkg::addr_t d_address,
    input  mem_types_pkg::line_t d_wdata,
    input  logic                 d_read,
    input  logic                 d_write,
    output mem_types_pkg::line_t d_rdata,
    output logic                 d_resp,

    line_bus_if.requester        pmem
);

    arb_pkg::arb_state_t state;
    arb_pkg::arb_state_t next_state;
    arb_pkg::mem_op_t    grant_op;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= arb_pkg::arb_idle;
        end else begin
            state <= next_state;
        end
    end

    // data port wins when both ask in idle.
    always_comb begin
        next_state = state;
        case (state)
            arb_pkg::arb_idle: begin
                if (d_read || d_write) begin
                    next_state = arb_pkg::arb_serve_d;
                end else if (i_read) begin
                    next_state = arb_pkg::arb_serve_i;
                end
            end
            arb_pkg::arb_serve_i,
            arb_pkg::arb_serve_d: begin
                if (pmem.resp) next_state = arb_pkg::arb_idle;
            end
            default: next_state = arb_pkg::arb_idle;
        endcase
    end

    always_comb begin
        grant_op     = arb_pkg::op_none;
        pmem.address = '0;
        pmem.wdata   = '0;
        i_rdata      = '0;
        i_resp       = 1'b0;
        d_rdata      = '0;
        d_resp       = 1'b0;
        case (state)
            arb_pkg::arb_serve_i: begin
                grant_op     = arb_pkg::op_read;
                pmem.address = i_address;
                i_rdata      = pmem.rdata;
                i_resp       = pmem.resp;
            end
            arb_pkg::arb_serve_d: begin
                grant_op     = d_read ? arb_pkg::op_read : arb_pkg::op_write;
                pmem.address = d_address;
                pmem.wdata   = d_wdata;
                d_rdata      = pmem.rdata;
                d_resp       = pmem.resp;
            end
            default: ;
        endcase
    end

    assign pmem.read  = (grant_op == arb_pkg::op_read);
    assign pmem.write = (grant_op == arb_pkg::op_write);

endmodule

// ==== pmem/pmem_timer.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module pmem_timer (
    input  logic clk,
    input  logic rst,
    input  logic read,
    input  logic write,
    output logic resp
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic             busy;
    logic [CNT_W-1:0] count;
    arb_pkg::mem_op_t cur_op;

    assign cur_op = write ? arb_pkg::op_write :
                    read  ? arb_pkg::op_read  : arb_pkg::op_none;

    assign resp = busy && (count == CNT_W'(`MEM_LATENCY));

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (busy) begin
            if (resp) begin
                busy  <= 1'b0; // held request must not retrigger.
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end else if (cur_op != arb_pkg::op_none) begin
            busy  <= 1'b1;
            count <= CNT_W'(1);
        end
    end

    // requester holds the same level until resp.
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        busy |-> (cur_op != arb_pkg::op_none) && $stable(cur_op));

endmodule

// ==== pmem/pmem_array.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module pmem_array (
    input  logic     clk,
    input  logic     rst,
    line_bus_if.store bus
);

    mem_types_pkg::line_t     lines [`MEM_LINES];
    mem_types_pkg::line_idx_t idx;

    assign idx = mem_types_pkg::line_index(bus.address);

    // write lands on the response cycle.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `MEM_LINES; i++) begin
                lines[i] <= '0;
            end
        end else if (bus.write && bus.resp) begin
            lines[idx] <= bus.wdata;
        end
    end

    assign bus.rdata = lines[idx]; // valid whenever resp is.

endmodule

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem (
    input  logic                 clk,
    input  logic                 rst,

    input  mem_types_pkg::addr_t i_address,
    input  logic                 i_read,
    output mem_types_pkg::line_t i_rdata,
    output logic                 i_resp,

    input  mem_types_pkg::addr_t d_address,
    input  mem_types_pkg::line_t d_wdata,
    input  logic                 d_read,
    input  logic                 d_write,
    output mem_types_pkg::line_t d_rdata,
    output logic                 d_resp
);

    line_bus_if pmem_bus ();

    arbiter u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .i_address (i_address),
        .i_read    (i_read),
        .i_rdata   (i_rdata),
        .i_resp    (i_resp),
        .d_address (d_address),
        .d_wdata   (d_wdata),
        .d_read    (d_read),
        .d_write   (d_write),
        .d_rdata   (d_rdata),
        .d_resp    (d_resp),
        .pmem      (pmem_bus)
    );

    // timer owns resp, array owns rdata.
    pmem_timer u_pmem_timer (
        .clk   (clk),
        .rst   (rst),
        .read  (pmem_bus.read),
        .write (pmem_bus.write),
        .resp  (pmem_bus.resp)
    );

    pmem_array u_pmem_array (
        .clk (clk),
        .rst (rst),
        .bus (pmem_bus)
    );

endmodule

// ==== bench/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`include "mem_consts.svh"

module tb_mem_subsystem;

    localparam int WAIT_LIMIT = 50;
    localparam int RANDOM_OPS = 200;

    logic                 clk;
    logic                 rst;
    mem_types_pkg::addr_t i_address;
    logic                 i_read;
    mem_types_pkg::line_t i_rdata;
    logic                 i_resp;
    mem_types_pkg::addr_t d_address;
    mem_types_pkg::line_t d_wdata;
    logic                 d_read;
    logic                 d_write;
    mem_types_pkg::line_t d_rdata;
    logic                 d_resp;

    mem_types_pkg::line_t model [`MEM_LINES];
    int errors;
    int tests_run;
    int tests_failed;
    int resp_seen;

    mem_subsystem u_mem_subsystem (
        .clk       (clk),
        .rst       (rst),
        .i_address (i_address),
        .i_read    (i_read),
        .i_rdata   (i_rdata),
        .i_resp    (i_resp),
        .d_address (d_address),
        .d_wdata   (d_wdata),
        .d_read    (d_read),
        .d_write   (d_write),
        .d_rdata   (d_rdata),
        .d_resp    (d_resp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one port at a time on the memory.
    always @(negedge clk) begin
        if (!rst && i_resp && d_resp) begin
            $display("error: i_resp and d_resp were high in the same cycle");
            errors++;
        end
    end

    // line slot from the bits just above the byte offset.
    function automatic int model_slot(input mem_types_pkg::addr_t address);
        return int'(address[`MEM_OFFSET_BITS +: $clog2(`MEM_LINES)]);
    endfunction

    function automatic mem_types_pkg::line_t random_line();
        mem_types_pkg::line_t value;
        for (int w = 0; w < `MEM_LINE_W / 32; w++) begin
            value[w*32 +: 32] = $urandom;
        end
        return value;
    endfunction

    task automatic check_line(input string name, input mem_types_pkg::line_t got,
                              input mem_types_pkg::line_t expected);
        if (got !== expected) begin
            $display("Fail %s: got 0x%h expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_resp(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("Fail %s: got 0x%h expected 0x%h", name, got, expected);
            errors++;
        end
    endtask

    task automatic check_order(input time d_at, input time i_at);
        if (d_at == i_at) begin
            $display("error: data and instruction responses arrived in the same cycle");
            errors++;
        end else if (i_at < d_at) begin
            $display("error: instruction port was answered before the data port");
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int err_mark);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
    endtask

    // cycles counted from the edge that first samples the request.
    task automatic instr_read(input mem_types_pkg::addr_t address, input int delay,
                              output int cycles, output time at);
        bit answered;
        answered = 1'b0;
        cycles   = 0;
        at       = 0;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        i_address <= address;
        i_read    <= 1'b1;
        @(posedge clk);
        do begin
            @(negedge clk);
            cycles++;
        end while (!i_resp && cycles < WAIT_LIMIT);
        if (i_resp) begin
            answered = 1'b1;
            at       = $time;
            resp_seen++;
            check_line("i_rdata", i_rdata, model[model_slot(address)]);
        end else begin
            $display("error: no i_resp within %0d cycles", WAIT_LIMIT);
            errors++;
        end
        @(posedge clk);
        i_read <= 1'b0;
        @(negedge clk);
        if (answered) check_resp("i_resp width", i_resp ? 2 : 1, 1);
    endtask

    task automatic data_op(input bit is_write, input mem_types_pkg::addr_t address,
                           input mem_types_pkg::line_t wdata, input int delay,
                           output int cycles, output time at);
        bit answered;
        answered = 1'b0;
        cycles   = 0;
        at       = 0;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        d_address <= address;
        d_wdata   <= wdata;
        d_read    <= !is_write;
        d_write   <= is_write;
        @(posedge clk);
        do begin
            @(negedge clk);
            cycles++;
        end while (!d_resp && cycles < WAIT_LIMIT);
        if (d_resp) begin
            answered = 1'b1;
            at       = $time;
            resp_seen++;
            if (is_write) model[model_slot(address)] = wdata; // lands on this resp.
            else check_line("d_rdata", d_rdata, model[model_slot(address)]);
        end else begin
            $display("error: no d_resp within %0d cycles", WAIT_LIMIT);
            errors++;
        end
        @(posedge clk);
        d_read  <= 1'b0;
        d_write <= 1'b0;
        @(negedge clk);
        if (answered) check_resp("d_resp width", d_resp ? 2 : 1, 1);
    endtask

    initial begin
        int                   err_mark;
        int                   cycles_i;
        int                   cycles_d;
        time                  at_i;
        time                  at_d;
        int                   mode;
        int                   requests;
        bit                   use_d;
        bit                   use_i;
        bit                   is_write;
        int                   delay_d;
        int                   delay_i;
        mem_types_pkg::addr_t addr_a;
        mem_types_pkg::addr_t addr_b;
        mem_types_pkg::line_t line_a;

        void'($urandom(32'hbbdff4aa));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        resp_seen    = 0;
        for (int s = 0; s < `MEM_LINES; s++) begin
            model[s] = '0;
        end
        rst       <= 1'b1;
        i_address <= '0;
        i_read    <= 1'b0;
        d_address <= '0;
        d_wdata   <= '0;
        d_read    <= 1'b0;
        d_write   <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        err_mark = errors;
        @(negedge clk);
        check_resp("i_resp after reset", int'(i_resp), 0);
        check_resp("d_resp after reset", int'(d_resp), 0);
        instr_read($urandom, 0, cycles_i, at_i);
        finish_test("reset and zero read", err_mark);

        err_mark = errors;
        addr_a   = $urandom;
        addr_b   = addr_a + 32'(1 << `MEM_OFFSET_BITS); // next line slot.
        line_a   = random_line();
        data_op(1'b1, addr_a, line_a, 0, cycles_d, at_d);
        instr_read(addr_a, 0, cycles_i, at_i);
        data_op(1'b0, addr_b, '0, 0, cycles_d, at_d);
        finish_test("write then read back", err_mark);

        err_mark = errors;
        instr_read($urandom, 0, cycles_i, at_i);
        check_resp("i_resp latency", cycles_i, `MEM_LATENCY + 1);
        data_op(1'b1, $urandom, random_line(), 0, cycles_d, at_d);
        check_resp("d_resp write latency", cycles_d, `MEM_LATENCY + 1);
        data_op(1'b0, $urandom, '0, 0, cycles_d, at_d);
        check_resp("d_resp read latency", cycles_d, `MEM_LATENCY + 1);
        finish_test("fixed latency", err_mark);

        err_mark = errors;
        for (int k = 0; k < 2; k++) begin
            is_write = (k == 1);
            fork
                data_op(is_write, addr_b, random_line(), 0, cycles_d, at_d);
                instr_read(addr_a, 0, cycles_i, at_i);
            join
            check_order(at_d, at_i);
        end
        finish_test("data port priority", err_mark);

        err_mark  = errors;
        resp_seen = 0;
        requests  = 0;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            mode     = $urandom_range(3, 0);
            use_d    = (mode != 1);
            use_i    = (mode != 0);
            delay_d  = (mode == 3) ? $urandom_range(3, 0) : 0;
            delay_i  = (mode == 3) ? $urandom_range(3, 0) : 0;
            is_write = $urandom_range(1, 0) == 1;
            addr_a   = $urandom;
            addr_b   = $urandom;
            line_a   = random_line();
            requests += int'(use_d) + int'(use_i);
            fork
                begin
                    if (use_d) data_op(is_write, addr_a, line_a, delay_d, cycles_d, at_d);
                end
                begin
                    if (use_i) instr_read(addr_b, delay_i, cycles_i, at_i);
                end
            join
        end
        check_resp("responses", resp_seen, requests);
        finish_test("random traffic", err_mark);

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+common
common/mem_types_pkg.sv
common/arb_pkg.sv
common/line_bus_if.sv
arbiter/arbiter.sv
pmem/pmem_timer.sv
pmem/pmem_array.sv
src/mem_subsystem.sv
bench/tb_mem_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with verilator, run, and decide the result from the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_mem_subsystem -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat build.log; [ -f sim.log ] && cat sim.log; echo "build or run failed"; exit 1; }

cat sim.log

grep -qx "PASS: all tests" sim.log \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }
